//--- hw/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Default system clock frequency in Hz.
`define PERIPH_CLOCK_HZ 50000000

// Millisecond tick rate.
`define PERIPH_TICK_HZ 1000

// Number of interrupt sources into the controller.
`define PERIPH_IRQ_LINES 2

`endif

//--- hw/periph_bus_pkg.sv
package periph_bus_pkg;

	// Word address, device in bits 7..4, register in bits 3..0.
	typedef logic [7:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0] reg_index_t;

	// Device select taken from the high address nibble.
	typedef enum logic [3:0] {
		SEL_TIMER = 4'd0,
		SEL_INTC = 4'd1
	} periph_select_e;

	// Interrupt controller registers.
	typedef enum logic [3:0] {
		INTC_PENDING = 4'd0,
		INTC_ENABLE = 4'd1
	} intc_reg_e;

endpackage

//--- hw/timer_pkg.sv
package timer_pkg;

	// Free-running cycle count and compare value.
	typedef logic [63:0] cycles_t;

	// Millisecond count and countdown value.
	typedef logic [31:0] count_t;

	typedef enum logic [1:0] {
		MODE_OFF = 2'd0,
		MODE_COMPARE = 2'd1,
		MODE_COUNTDOWN = 2'd2
	} timer_mode_e;

	// Register map within the timer.
	typedef enum logic [3:0] {
		REG_MS = 4'd0,
		REG_CYCLES_LO = 4'd1,
		REG_CYCLES_HI = 4'd2,
		REG_COMPARE_LO = 4'd3,
		REG_COMPARE_HI = 4'd4,
		REG_COUNTDOWN = 4'd5
	} timer_reg_e;

endpackage

//--- hw/periph_bus_decoder.sv
`timescale 1ns/100ps

module periph_bus_decoder
	import periph_bus_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input bus_addr_t i_address,

	output bus_data_t o_rdata,
	output logic o_ready,

	output logic o_timer_request,
	output logic o_intc_request,

	input bus_data_t i_timer_rdata,
	input bus_data_t i_intc_rdata,
	input logic i_timer_ready,
	input logic i_intc_ready
);
	periph_select_e select;
	logic unmapped;
	logic unmapped_request;
	logic unmapped_request_q;
	logic unmapped_ready;
	bus_data_t device_rdata;
	logic device_ready;

	assign select = periph_select_e'(i_address[7:4]);
	assign unmapped = (select != SEL_TIMER) && (select != SEL_INTC);
	assign unmapped_request = i_request && unmapped;

	// Request level goes only to the addressed device.
	assign o_timer_request = i_request && (select == SEL_TIMER);
	assign o_intc_request = i_request && (select == SEL_INTC);

	// Unmapped accesses are acknowledged here so the CPU never stalls.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			unmapped_request_q <= 1'b0;
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_request_q <= unmapped_request;
			if (unmapped_request && !unmapped_request_q) begin
				unmapped_ready <= 1'b1;
			end else if (!i_request) begin
				unmapped_ready <= 1'b0;
			end
		end
	end

	always_comb begin
		case (select)
			SEL_TIMER: begin
				device_rdata = i_timer_rdata;
				device_ready = i_timer_ready;
			end
			SEL_INTC: begin
				device_rdata = i_intc_rdata;
				device_ready = i_intc_ready;
			end
			default: begin
				device_rdata = '0;
				device_ready = unmapped_ready;
			end
		endcase
	end

	// Write acknowledges carry zero instead of stale read data.
	assign o_rdata = i_rw ? '0 : device_rdata;
	assign o_ready = device_ready;

endmodule

//--- hw/timer.sv
`timescale 1ns/100ps

`include "periph_config.svh"

module timer
	import periph_bus_pkg::*, timer_pkg::*;
#(
	parameter int FREQUENCY = `PERIPH_CLOCK_HZ
)(
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input reg_index_t i_register,
	input bus_data_t i_wdata,

	output bus_data_t o_rdata,
	output logic o_ready,

	output logic o_interrupt
);
	// Cycles per millisecond tick, counted from zero.
	localparam int PRESCALE = FREQUENCY / `PERIPH_TICK_HZ - 1;
	localparam int PRESCALE_WIDTH = (PRESCALE > 0) ? $clog2(PRESCALE + 1) : 1;

	logic [PRESCALE_WIDTH-1:0] prescale;
	count_t ms;
	cycles_t cycles;
	cycles_t compare;
	count_t countdown;
	timer_mode_e mode;
	timer_reg_e register;
	logic request_q;
	logic access;

	assign register = timer_reg_e'(i_register);
	assign access = i_request && !request_q;

	// Millisecond counter behind the prescaler.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			ms <= '0;
		end else if (prescale == PRESCALE_WIDTH'(PRESCALE)) begin
			prescale <= '0;
			ms <= ms + count_t'(1);
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			cycles <= '0;
		end else begin
			cycles <= cycles + cycles_t'(1);
		end
	end

	// Compare, countdown and mode, with bus writes taking priority.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			compare <= '1;
			countdown <= '0;
			mode <= MODE_OFF;
		end else begin
			if (countdown != '0) begin
				countdown <= countdown - count_t'(1);
			end
			if (access && i_rw) begin
				case (register)
					REG_COMPARE_LO: begin
						compare[31:0] <= i_wdata;
						mode <= MODE_COMPARE;
					end
					REG_COMPARE_HI: begin
						compare[63:32] <= i_wdata;
						mode <= MODE_COMPARE;
					end
					REG_COUNTDOWN: begin
						countdown <= i_wdata;
						mode <= MODE_COUNTDOWN;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// One-cycle pulse the cycle after the condition holds.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_interrupt <= 1'b0;
		end else begin
			case (mode)
				MODE_COMPARE: o_interrupt <= (cycles == compare);
				MODE_COUNTDOWN: o_interrupt <= (countdown == count_t'(1));
				default: o_interrupt <= 1'b0;
			endcase
		end
	end

	// Bus handshake.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			request_q <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			request_q <= i_request;
			if (access) begin
				o_ready <= 1'b1;
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

	// Read data sampled on the request edge.
	always_ff @(posedge i_clock) begin
		if (access && !i_rw) begin
			case (register)
				REG_MS: o_rdata <= ms;
				REG_CYCLES_LO: o_rdata <= cycles[31:0];
				REG_CYCLES_HI: o_rdata <= cycles[63:32];
				REG_COMPARE_LO: o_rdata <= compare[31:0];
				REG_COMPARE_HI: o_rdata <= compare[63:32];
				REG_COUNTDOWN: o_rdata <= countdown;
				default: o_rdata <= '0;
			endcase
		end
	end

endmodule

//--- hw/interrupt_controller.sv
`timescale 1ns/100ps

`include "periph_config.svh"

module interrupt_controller
	import periph_bus_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input reg_index_t i_register,
	input bus_data_t i_wdata,

	output bus_data_t o_rdata,
	output logic o_ready,

	input logic [`PERIPH_IRQ_LINES-1:0] i_sources,
	output logic o_irq
);
	localparam int IRQ_LINES = `PERIPH_IRQ_LINES;

	logic [IRQ_LINES-1:0] pending;
	logic [IRQ_LINES-1:0] enable;
	logic [IRQ_LINES-1:0] clear;
	intc_reg_e register;
	logic request_q;
	logic access;

	assign register = intc_reg_e'(i_register);
	assign access = i_request && !request_q;

	// Write 1 to clear.
	assign clear = (access && i_rw && register == INTC_PENDING) ?
		i_wdata[IRQ_LINES-1:0] : '0;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pending <= '0;
			enable <= '0;
		end else begin
			// New pulses win over a clear in the same cycle.
			pending <= (pending & ~clear) | i_sources;
			if (access && i_rw && register == INTC_ENABLE) begin
				enable <= i_wdata[IRQ_LINES-1:0];
			end
		end
	end

	// Bus handshake.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			request_q <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			request_q <= i_request;
			if (access) begin
				o_ready <= 1'b1;
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access && !i_rw) begin
			case (register)
				INTC_PENDING: o_rdata <= {{(32 - IRQ_LINES){1'b0}}, pending};
				INTC_ENABLE: o_rdata <= {{(32 - IRQ_LINES){1'b0}}, enable};
				default: o_rdata <= '0;
			endcase
		end
	end

	// Level interrupt to the CPU.
	assign o_irq = |(pending & enable);

endmodule

//--- hw/periph_subsystem.sv
`timescale 1ns/100ps

`include "periph_config.svh"

module periph_subsystem
	import periph_bus_pkg::*;
#(
	parameter int FREQUENCY = `PERIPH_CLOCK_HZ
)(
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input bus_addr_t i_address,
	input bus_data_t i_wdata,
	input logic i_ext_irq,

	output bus_data_t o_rdata,
	output logic o_ready,
	output logic o_irq
);
	reg_index_t register_index;
	logic timer_request;
	logic intc_request;
	bus_data_t timer_rdata;
	bus_data_t intc_rdata;
	logic timer_ready;
	logic intc_ready;
	logic timer_interrupt;
	logic [`PERIPH_IRQ_LINES-1:0] irq_sources;

	assign register_index = i_address[3:0];

	// Source 0 is the timer, source 1 the external line.
	assign irq_sources = {i_ext_irq, timer_interrupt};

	periph_bus_decoder i_decoder (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_timer_request(timer_request),
		.o_intc_request(intc_request),
		.i_timer_rdata(timer_rdata),
		.i_intc_rdata(intc_rdata),
		.i_timer_ready(timer_ready),
		.i_intc_ready(intc_ready)
	);

	timer #(
		.FREQUENCY(FREQUENCY)
	) i_timer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(timer_request),
		.i_rw(i_rw),
		.i_register(register_index),
		.i_wdata(i_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_interrupt(timer_interrupt)
	);

	interrupt_controller i_intc (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(intc_request),
		.i_rw(i_rw),
		.i_register(register_index),
		.i_wdata(i_wdata),
		.o_rdata(intc_rdata),
		.o_ready(intc_ready),
		.i_sources(irq_sources),
		.o_irq(o_irq)
	);

endmodule

//--- testbench/tb_periph_subsystem.sv
`timescale 1ns/100ps

`include "periph_config.svh"

module tb_periph_subsystem
	import periph_bus_pkg::*, timer_pkg::*;
;
	localparam int FREQUENCY = 8000;
	localparam int CYCLES_PER_MS = FREQUENCY / `PERIPH_TICK_HZ;

	// The tests need a few hundred cycles, so this leaves a wide margin.
	localparam int TIMEOUT_CYCLES = 3000;

	localparam bus_addr_t ADDR_MS = {SEL_TIMER, REG_MS};
	localparam bus_addr_t ADDR_CYCLES_LO = {SEL_TIMER, REG_CYCLES_LO};
	localparam bus_addr_t ADDR_CYCLES_HI = {SEL_TIMER, REG_CYCLES_HI};
	localparam bus_addr_t ADDR_COMPARE_LO = {SEL_TIMER, REG_COMPARE_LO};
	localparam bus_addr_t ADDR_COMPARE_HI = {SEL_TIMER, REG_COMPARE_HI};
	localparam bus_addr_t ADDR_COUNTDOWN = {SEL_TIMER, REG_COUNTDOWN};
	localparam bus_addr_t ADDR_PENDING = {SEL_INTC, INTC_PENDING};
	localparam bus_addr_t ADDR_ENABLE = {SEL_INTC, INTC_ENABLE};

	logic i_clock;
	logic i_reset;
	logic i_request;
	logic i_rw;
	bus_addr_t i_address;
	bus_data_t i_wdata;
	logic i_ext_irq;
	bus_data_t o_rdata;
	logic o_ready;
	logic o_irq;

	int cycle_count = 0;
	int request_cycle = 0;
	int pass_count = 0;
	int fail_count = 0;
	integer seed = 79;

	periph_subsystem #(
		.FREQUENCY(FREQUENCY)
	) i_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_ext_irq(i_ext_irq),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_irq(o_irq)
	);

	always #20 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			fail_count++;
			$display("FAILED at %0t ns: %s: got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
		end else begin
			pass_count++;
		end
	endtask

	task automatic next_cycle();
		@(posedge i_clock);
		#2;
	endtask

	// One full handshake that runs until ready has dropped again.
	task automatic handshake(input logic rw, input bus_addr_t address,
			input bus_data_t wdata, output bus_data_t rdata);
		int rise_cycles;
		int fall_cycles;
		i_request = 1'b1;
		i_rw = rw;
		i_address = address;
		i_wdata = wdata;
		request_cycle = cycle_count;
		rise_cycles = 0;
		do begin
			next_cycle();
			rise_cycles++;
		end while (!o_ready);
		check_value("cycles from request to ready", rise_cycles, 1);
		rdata = o_rdata;
		i_request = 1'b0;
		fall_cycles = 0;
		do begin
			next_cycle();
			fall_cycles++;
		end while (o_ready);
		check_value("cycles from request drop to ready drop", fall_cycles, 1);
	endtask

	task automatic bus_write(input bus_addr_t address, input bus_data_t data);
		bus_data_t unused;
		handshake(1'b1, address, data, unused);
	endtask

	task automatic bus_read(input bus_addr_t address, output bus_data_t data);
		handshake(1'b0, address, '0, data);
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (fail_count == fails_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d mismatches", name, fail_count - fails_before);
		end
	endtask

	task automatic reset_state_and_unmapped();
		int fails_before;
		bus_data_t data;
		fails_before = fail_count;
		bus_read(ADDR_COMPARE_LO, data);
		check_value("compare low after reset", data, 32'hffff_ffff);
		bus_read(ADDR_COMPARE_HI, data);
		check_value("compare high after reset", data, 32'hffff_ffff);
		bus_read(ADDR_COUNTDOWN, data);
		check_value("countdown after reset", data, 0);
		bus_read(ADDR_PENDING, data);
		check_value("pending after reset", data, 0);
		bus_read(ADDR_ENABLE, data);
		check_value("enable after reset", data, 0);
		check_value("irq after reset", o_irq, 0);
		bus_read(8'h50, data);
		check_value("unmapped read", data, 0);
		// Same register numbers as compare low and enable, on device 5.
		bus_write(8'h53, 32'h1234_5678);
		bus_write(8'h51, 32'h3);
		bus_read(ADDR_COMPARE_LO, data);
		check_value("compare low after unmapped write", data, 32'hffff_ffff);
		bus_read(ADDR_ENABLE, data);
		check_value("enable after unmapped write", data, 0);
		report_test("reset state and unmapped access", fails_before);
	endtask

	task automatic cycle_count_difference();
		int fails_before;
		int first_request;
		int gap;
		bus_data_t first;
		bus_data_t second;
		bus_data_t data;
		fails_before = fail_count;
		bus_read(ADDR_CYCLES_LO, first);
		first_request = request_cycle;
		gap = 5 + ({$random(seed)} % 20);
		repeat (gap) next_cycle();
		bus_read(ADDR_CYCLES_LO, second);
		check_value("cycle count difference", second - first, request_cycle - first_request);
		bus_read(ADDR_CYCLES_HI, data);
		check_value("cycle count high word", data, 0);
		report_test("cycle counter", fails_before);
	endtask

	task automatic ms_follows_cycles();
		int fails_before;
		int cycles_request;
		bus_data_t cycles;
		bus_data_t ms;
		fails_before = fail_count;
		for (int i = 0; i < 4; i++) begin
			bus_read(ADDR_CYCLES_LO, cycles);
			cycles_request = request_cycle;
			repeat ({$random(seed)} % 24) next_cycle();
			bus_read(ADDR_MS, ms);
			// Both counters start together, so ms is the cycle count over the prescale.
			cycles = cycles + (request_cycle - cycles_request);
			check_value("ms against cycles", ms, cycles / CYCLES_PER_MS);
		end
		report_test("millisecond counter", fails_before);
	endtask

	task automatic countdown_interrupt();
		int fails_before;
		int limit;
		bus_data_t count;
		bus_data_t data;
		fails_before = fail_count;
		bus_write(ADDR_ENABLE, 32'h1);
		count = 10 + ({$random(seed)} % 31);
		bus_write(ADDR_COUNTDOWN, count);
		limit = request_cycle + count + 3;
		while (!o_irq && cycle_count < limit) begin
			next_cycle();
		end
		check_value("irq after countdown", o_irq, 1);
		bus_read(ADDR_PENDING, data);
		check_value("pending after countdown", data, 1);
		bus_write(ADDR_PENDING, 32'h1);
		check_value("irq after pending clear", o_irq, 0);
		bus_read(ADDR_PENDING, data);
		check_value("pending after clear", data, 0);
		report_test("countdown interrupt", fails_before);
	endtask

	task automatic compare_interrupt_masking();
		int fails_before;
		int start;
		logic irq_seen;
		bus_data_t low;
		bus_data_t high;
		bus_data_t data;
		cycles_t target;
		fails_before = fail_count;
		bus_write(ADDR_ENABLE, 32'h0);
		bus_read(ADDR_CYCLES_LO, low);
		start = request_cycle;
		bus_read(ADDR_CYCLES_HI, high);
		target = {high, low} + cycles_t'(60);
		bus_write(ADDR_COMPARE_HI, target[63:32]);
		bus_write(ADDR_COMPARE_LO, target[31:0]);
		irq_seen = 1'b0;
		while (cycle_count < start + 80) begin
			next_cycle();
			if (o_irq) begin
				irq_seen = 1'b1;
			end
		end
		check_value("irq while masked", irq_seen, 0);
		bus_read(ADDR_PENDING, data);
		check_value("pending after compare", data, 1);
		bus_write(ADDR_ENABLE, 32'h1);
		check_value("irq after enable", o_irq, 1);
		bus_write(ADDR_PENDING, 32'h1);
		check_value("irq after compare clear", o_irq, 0);
		report_test("compare interrupt and masking", fails_before);
	endtask

	task automatic external_interrupt();
		int fails_before;
		bus_data_t data;
		fails_before = fail_count;
		bus_write(ADDR_ENABLE, 32'h2);
		i_ext_irq = 1'b1;
		next_cycle();
		i_ext_irq = 1'b0;
		check_value("irq after external pulse", o_irq, 1);
		bus_read(ADDR_PENDING, data);
		check_value("pending after external pulse", data, 2);
		bus_write(ADDR_PENDING, 32'h2);
		check_value("irq after external clear", o_irq, 0);
		bus_read(ADDR_PENDING, data);
		check_value("pending after external clear", data, 0);
		report_test("external interrupt", fails_before);
	endtask

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_ext_irq = 1'b0;
		repeat (3) @(posedge i_clock);
		#2;
		i_reset = 1'b0;

		reset_state_and_unmapped();
		cycle_count_difference();
		ms_follows_cycles();
		countdown_interrupt();
		compare_interrupt_masking();
		external_interrupt();

		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+hw
hw/periph_bus_pkg.sv
hw/timer_pkg.sv
hw/periph_bus_decoder.sv
hw/timer.sv
hw/interrupt_controller.sv
hw/periph_subsystem.sv
testbench/tb_periph_subsystem.sv

//--- Bender.yml
package:
  name: periph_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/periph_bus_pkg.sv
      - hw/timer_pkg.sv
      - hw/periph_bus_decoder.sv
      - hw/timer.sv
      - hw/interrupt_controller.sv
      - hw/periph_subsystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_periph_subsystem.sv
